// ==== common/rename_consts.svh ====
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// Register file sizes
`define ARCH_REGS 32
`define PHYS_REGS 64

// Tag widths
`define PTAG_W 6
`define ATAG_W 5

// Slots per dispatch and retire bundle
`define RN_WIDTH 3

`endif

// ==== common/rename_pkg.sv ====
`include "rename_consts.svh"

package rename_pkg;

	typedef logic [`PTAG_W-1:0] ptag_t; // Physical register tag
	typedef logic [`ATAG_W-1:0] atag_t; // Architectural register index
	typedef logic [$clog2(`RN_WIDTH+1)-1:0] cred_t; // 0 to RN_WIDTH

	typedef struct packed {
		logic valid;
		logic has_dest;
		atag_t dest;
		atag_t src1;
		atag_t src2;
	} rn_in_slot_t;

	typedef struct packed {
		logic valid;
		logic has_dest;
		ptag_t pdest;
		ptag_t prev_pdest; // Mapping replaced by pdest
		ptag_t psrc1;
		ptag_t psrc2;
	} rn_out_slot_t;

	typedef struct packed {
		logic valid;
		atag_t dest;
		ptag_t pdest;
		ptag_t prev_pdest; // Goes back to the free list
	} rt_slot_t;

endpackage

// ==== common/free_port_if.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

interface free_port_if import rename_pkg::*; ();

	logic [`RN_WIDTH-1:0] alloc_en; // One request per slot
	ptag_t [`RN_WIDTH-1:0] alloc_tag;
	cred_t credits; // Destinations allowed next bundle
	logic [`RN_WIDTH-1:0] release_en;
	ptag_t [`RN_WIDTH-1:0] release_tag;
	logic recover;

	modport alloc_side (
		output alloc_en,
		input alloc_tag,
		input credits
	);

	modport list_side (
		input alloc_en,
		output alloc_tag,
		output credits,
		input release_en,
		input release_tag,
		input recover
	);

endinterface

// ==== rtl/free_list/free_list.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module free_list import rename_pkg::*; (
	input logic clock,
	input logic reset,
	free_port_if.list_side fl
);

	localparam int DEPTH = `PHYS_REGS - `ARCH_REGS;
	localparam int PTR_W = $clog2(DEPTH);

	ptag_t ring [DEPTH];
	ptag_t ring_next [DEPTH];
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] head_next;
	logic [PTR_W-1:0] tail;
	logic [PTR_W-1:0] tail_next;
	logic full;
	logic full_next;
	logic [PTR_W:0] free_cnt;
	logic [PTR_W-1:0] alloc_cnt;
	logic [PTR_W-1:0] rel_cnt;

	// Head equals tail both when empty and when full
	assign free_cnt = full ? (PTR_W+1)'(DEPTH) : {1'b0, tail - head};

	always_comb begin
		if (free_cnt >= `RN_WIDTH)
			fl.credits = cred_t'(`RN_WIDTH);
		else
			fl.credits = cred_t'(free_cnt);
	end

	// Granted slots take consecutive entries from head
	always_comb begin
		logic [PTR_W-1:0] offs;
		offs = '0;
		for (int i = 0; i < `RN_WIDTH; i++) begin
			fl.alloc_tag[i] = ring[head + offs];
			offs = offs + PTR_W'(fl.alloc_en[i]);
		end
		alloc_cnt = offs;
	end

	// Released tags appended at tail in slot order
	always_comb begin
		logic [PTR_W-1:0] offs;
		ring_next = ring;
		offs = '0;
		for (int i = 0; i < `RN_WIDTH; i++) begin
			if (fl.release_en[i]) begin
				ring_next[tail + offs] = fl.release_tag[i];
				offs = offs + 1'b1;
			end
		end
		rel_cnt = offs;
	end

	assign head_next = head + alloc_cnt;
	assign tail_next = tail + rel_cnt;
	assign full_next = (rel_cnt != '0 || full) && (tail_next == head_next);

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			full <= 1'b1;
			for (int i = 0; i < DEPTH; i++)
				ring[i] <= ptag_t'(`ARCH_REGS + i); // Upper half starts free
		end else begin
			ring <= ring_next;
			tail <= tail_next;
			if (fl.recover) begin
				head <= tail_next; // Every in-flight tag comes back
				full <= 1'b1;
			end else begin
				head <= head_next;
				full <= full_next;
			end
		end
	end

	// Rename stage must respect the credits it was given
	assert property (@(posedge clock) disable iff (reset)
		$countones(fl.alloc_en) <= fl.credits)
		else $error("free list: allocation beyond credits");

	// Nothing can retire while no physical tag is in flight
	assert property (@(posedge clock) disable iff (reset)
		full |-> fl.release_en == '0)
		else $error("free list: release while full");

endmodule

// ==== rtl/map_table/map_table.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module map_table import rename_pkg::*; (
	input logic clock,
	input logic reset,
	input atag_t [`RN_WIDTH-1:0][1:0] lookup_src,
	input atag_t [`RN_WIDTH-1:0] lookup_dest,
	output ptag_t [`RN_WIDTH-1:0][1:0] lookup_psrc,
	output ptag_t [`RN_WIDTH-1:0] lookup_prev,
	input logic [`RN_WIDTH-1:0] spec_we,
	input ptag_t [`RN_WIDTH-1:0] spec_tag,
	input rt_slot_t [`RN_WIDTH-1:0] retire,
	input logic recover
);

	ptag_t spec_map [`ARCH_REGS];
	ptag_t arch_map [`ARCH_REGS];
	ptag_t spec_next [`ARCH_REGS];
	ptag_t arch_next [`ARCH_REGS];

	// Lookups see the map before this bundle's writes
	always_comb begin
		for (int i = 0; i < `RN_WIDTH; i++) begin
			lookup_psrc[i][0] = spec_map[lookup_src[i][0]];
			lookup_psrc[i][1] = spec_map[lookup_src[i][1]];
			lookup_prev[i] = spec_map[lookup_dest[i]];
		end
	end

	// Later slots overwrite earlier ones
	always_comb begin
		arch_next = arch_map;
		for (int i = 0; i < `RN_WIDTH; i++) begin
			if (retire[i].valid)
				arch_next[retire[i].dest] = retire[i].pdest;
		end
	end

	always_comb begin
		spec_next = spec_map;
		for (int i = 0; i < `RN_WIDTH; i++) begin
			if (spec_we[i])
				spec_next[lookup_dest[i]] = spec_tag[i];
		end
		if (recover)
			spec_next = arch_next; // Includes this cycle's retirements
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `ARCH_REGS; i++) begin
				spec_map[i] <= ptag_t'(i);
				arch_map[i] <= ptag_t'(i);
			end
		end else begin
			spec_map <= spec_next;
			arch_map <= arch_next;
		end
	end

	// Retired tag and the one it frees must differ, or a live tag is freed
	for (genvar i = 0; i < `RN_WIDTH; i++) begin : g_retire_chk
		assert property (@(posedge clock) disable iff (reset)
			retire[i].valid |-> retire[i].pdest != retire[i].prev_pdest)
			else $error("map table: slot %0d retires onto its own previous tag", i);
	end

endmodule

// ==== rtl/rename_stage.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_stage import rename_pkg::*; (
	input logic clock,
	input logic reset,
	input rn_in_slot_t [`RN_WIDTH-1:0] in_slots,
	input logic recover,
	free_port_if.alloc_side fl,
	output atag_t [`RN_WIDTH-1:0][1:0] lookup_src,
	output atag_t [`RN_WIDTH-1:0] lookup_dest,
	input ptag_t [`RN_WIDTH-1:0][1:0] lookup_psrc,
	input ptag_t [`RN_WIDTH-1:0] lookup_prev,
	output logic [`RN_WIDTH-1:0] spec_we,
	output ptag_t [`RN_WIDTH-1:0] spec_tag,
	output rn_out_slot_t [`RN_WIDTH-1:0] out_slots,
	output logic out_valid
);

	logic [`RN_WIDTH-1:0] grant;
	logic [`RN_WIDTH-1:0] in_valid;
	rn_out_slot_t [`RN_WIDTH-1:0] renamed;

	always_comb begin
		for (int i = 0; i < `RN_WIDTH; i++) begin
			in_valid[i] = in_slots[i].valid;
			grant[i] = in_slots[i].valid & in_slots[i].has_dest & ~recover;
			lookup_src[i][0] = in_slots[i].src1;
			lookup_src[i][1] = in_slots[i].src2;
			lookup_dest[i] = in_slots[i].dest;
		end
	end

	assign fl.alloc_en = grant;
	assign spec_we = grant;
	assign spec_tag = fl.alloc_tag;

	// Nearest older writer in the bundle wins, so scan oldest first
	always_comb begin
		for (int i = 0; i < `RN_WIDTH; i++) begin
			renamed[i].valid = in_slots[i].valid & ~recover;
			renamed[i].has_dest = in_slots[i].has_dest;
			renamed[i].pdest = fl.alloc_tag[i];
			renamed[i].prev_pdest = lookup_prev[i];
			renamed[i].psrc1 = lookup_psrc[i][0];
			renamed[i].psrc2 = lookup_psrc[i][1];
			for (int j = 0; j < i; j++) begin
				if (grant[j] && in_slots[j].dest == in_slots[i].src1)
					renamed[i].psrc1 = fl.alloc_tag[j];
				if (grant[j] && in_slots[j].dest == in_slots[i].src2)
					renamed[i].psrc2 = fl.alloc_tag[j];
				if (grant[j] && in_slots[j].dest == in_slots[i].dest)
					renamed[i].prev_pdest = fl.alloc_tag[j];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= (|in_valid) & ~recover; // Flushed bundle never shows
	end

	always_ff @(posedge clock) begin
		out_slots <= renamed;
	end

endmodule

// ==== rtl/rename_unit.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_unit import rename_pkg::*; (
	input logic clock,
	input logic reset,
	input rn_in_slot_t [`RN_WIDTH-1:0] in_slots,
	input logic in_recover,
	input rt_slot_t [`RN_WIDTH-1:0] ret_slots,
	output cred_t credits,
	output rn_out_slot_t [`RN_WIDTH-1:0] out_slots,
	output logic out_valid
);

	atag_t [`RN_WIDTH-1:0][1:0] lookup_src;
	atag_t [`RN_WIDTH-1:0] lookup_dest;
	ptag_t [`RN_WIDTH-1:0][1:0] lookup_psrc;
	ptag_t [`RN_WIDTH-1:0] lookup_prev;
	logic [`RN_WIDTH-1:0] spec_we;
	ptag_t [`RN_WIDTH-1:0] spec_tag;

	free_port_if fl ();

	// Retiring instructions hand back the tag they displaced
	always_comb begin
		for (int i = 0; i < `RN_WIDTH; i++) begin
			fl.release_en[i] = ret_slots[i].valid;
			fl.release_tag[i] = ret_slots[i].prev_pdest;
		end
	end

	assign fl.recover = in_recover;
	assign credits = fl.credits;

	free_list u_free_list (
		.clock (clock),
		.reset (reset),
		.fl (fl.list_side)
	);

	map_table u_map_table (
		.clock (clock),
		.reset (reset),
		.lookup_src (lookup_src),
		.lookup_dest (lookup_dest),
		.lookup_psrc (lookup_psrc),
		.lookup_prev (lookup_prev),
		.spec_we (spec_we),
		.spec_tag (spec_tag),
		.retire (ret_slots),
		.recover (in_recover)
	);

	rename_stage u_rename_stage (
		.clock (clock),
		.reset (reset),
		.in_slots (in_slots),
		.recover (in_recover),
		.fl (fl.alloc_side),
		.lookup_src (lookup_src),
		.lookup_dest (lookup_dest),
		.lookup_psrc (lookup_psrc),
		.lookup_prev (lookup_prev),
		.spec_we (spec_we),
		.spec_tag (spec_tag),
		.out_slots (out_slots),
		.out_valid (out_valid)
	);

endmodule

// ==== sim/rename_tb.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_tb import rename_pkg::*; ();

	localparam int N_CYCLES = 400;
	localparam int FILL_CYCLES = 14; // Dispatch only, until the free list runs dry
	localparam int WATCHDOG_NS = (N_CYCLES + 10) * 4 + 400;

	logic clock;
	logic reset;
	rn_in_slot_t [`RN_WIDTH-1:0] in_slots;
	logic in_recover;
	rt_slot_t [`RN_WIDTH-1:0] ret_slots;
	cred_t credits;
	rn_out_slot_t [`RN_WIDTH-1:0] out_slots;
	logic out_valid;

	ptag_t spec_m [`ARCH_REGS];
	ptag_t arch_m [`ARCH_REGS];
	ptag_t free_q [$];
	rt_slot_t flight [$]; // Renamed but not retired, oldest first
	rn_out_slot_t [`RN_WIDTH-1:0] hold_slots;
	rn_out_slot_t [`RN_WIDTH-1:0] exp_slots;
	logic hold_valid;
	logic exp_valid;
	cred_t hold_credits;
	cred_t exp_credits;
	logic [`RN_WIDTH-1:0] live;

	rename_unit dut (
		.clock (clock),
		.reset (reset),
		.in_slots (in_slots),
		.in_recover (in_recover),
		.ret_slots (ret_slots),
		.credits (credits),
		.out_slots (out_slots),
		.out_valid (out_valid)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic mismatch(input string name, input int slot, input int expv, input int gotv);
		string sig;
		sig = (slot < 0) ? name : $sformatf("out_slots[%0d].%s", slot, name);
		abort_run($sformatf("[FAIL] %0t %s expected %0d got %0d", $time, sig, expv, gotv));
	endtask

	function automatic cred_t credit_limit(input int n);
		if (n > `RN_WIDTH)
			return cred_t'(`RN_WIDTH);
		else
			return cred_t'(n);
	endfunction

	// Mostly a few low registers, so slots in one bundle often collide
	function automatic atag_t pick_reg();
		if ($urandom % 4 == 0)
			return atag_t'($urandom % `ARCH_REGS);
		else
			return atag_t'($urandom % 6);
	endfunction

	task automatic run_cycle(input int cyc);
		rn_in_slot_t [`RN_WIDTH-1:0] bundle;
		rt_slot_t [`RN_WIDTH-1:0] ret;
		rn_out_slot_t [`RN_WIDTH-1:0] res;
		rt_slot_t entry;
		int n_ret;
		int avail;
		bit fill;
		bit quiet;
		bit rec;
		bit any;
		fill = cyc < FILL_CYCLES;
		quiet = cyc >= N_CYCLES; // Drain at the end
		n_ret = (fill || quiet) ? 0 : $urandom % (`RN_WIDTH + 1);
		if (n_ret > flight.size())
			n_ret = flight.size();
		rec = !fill && !quiet && (cyc % 97 == 40 || $urandom % 40 == 0);
		bundle = '0;
		ret = '0;
		res = '0;
		any = 1'b0;
		for (int i = 0; i < n_ret; i++) begin
			ret[i] = flight.pop_front();
			arch_m[ret[i].dest] = ret[i].pdest;
		end
		avail = free_q.size(); // Same as credits once capped at three slots
		for (int i = 0; i < `RN_WIDTH; i++) begin
			bundle[i].valid = !quiet && (fill || $urandom % 4 != 0);
			bundle[i].has_dest = bundle[i].valid && avail > 0 && (fill || $urandom % 3 != 0);
			bundle[i].dest = pick_reg();
			bundle[i].src1 = pick_reg();
			bundle[i].src2 = pick_reg();
			if (bundle[i].has_dest)
				avail--;
			any = any | bundle[i].valid;
		end
		// Renaming slot by slot in age order equals forwarding from older slots
		for (int i = 0; i < `RN_WIDTH; i++) begin
			res[i].valid = bundle[i].valid;
			res[i].has_dest = bundle[i].has_dest;
			res[i].psrc1 = spec_m[bundle[i].src1];
			res[i].psrc2 = spec_m[bundle[i].src2];
			res[i].prev_pdest = spec_m[bundle[i].dest];
			if (bundle[i].has_dest && !rec) begin
				res[i].pdest = free_q.pop_front();
				spec_m[bundle[i].dest] = res[i].pdest;
				entry.valid = 1'b1;
				entry.dest = bundle[i].dest;
				entry.pdest = res[i].pdest;
				entry.prev_pdest = res[i].prev_pdest;
				flight.push_back(entry);
			end
		end
		for (int i = 0; i < n_ret; i++)
			free_q.push_back(ret[i].prev_pdest); // Behind every tag already free
		if (rec) begin
			for (int k = flight.size() - 1; k >= 0; k--)
				free_q.push_front(flight[k].pdest); // Flushed tags start at the new head
			flight.delete();
			spec_m = arch_m;
		end
		hold_slots = res;
		hold_valid = any && !rec;
		hold_credits = credit_limit(free_q.size());
		in_slots <= bundle;
		ret_slots <= ret;
		in_recover <= rec;
	endtask

	always_comb begin
		for (int i = 0; i < `RN_WIDTH; i++)
			live[i] = exp_valid & exp_slots[i].valid;
	end

	assert property (@(posedge clock) disable iff (reset) out_valid == exp_valid)
		else mismatch("out_valid", -1, $sampled(exp_valid), $sampled(out_valid));
	assert property (@(posedge clock) disable iff (reset) credits == exp_credits)
		else mismatch("credits", -1, $sampled(exp_credits), $sampled(credits));

	for (genvar i = 0; i < `RN_WIDTH; i++) begin : g_slot_chk
		assert property (@(posedge clock) disable iff (reset)
			exp_valid |-> out_slots[i].valid == exp_slots[i].valid)
			else mismatch("valid", i, $sampled(exp_slots[i].valid), $sampled(out_slots[i].valid));
		assert property (@(posedge clock) disable iff (reset)
			live[i] |-> out_slots[i].has_dest == exp_slots[i].has_dest)
			else mismatch("has_dest", i, $sampled(exp_slots[i].has_dest),
				$sampled(out_slots[i].has_dest));
		assert property (@(posedge clock) disable iff (reset)
			live[i] |-> out_slots[i].psrc1 == exp_slots[i].psrc1)
			else mismatch("psrc1", i, $sampled(exp_slots[i].psrc1), $sampled(out_slots[i].psrc1));
		assert property (@(posedge clock) disable iff (reset)
			live[i] |-> out_slots[i].psrc2 == exp_slots[i].psrc2)
			else mismatch("psrc2", i, $sampled(exp_slots[i].psrc2), $sampled(out_slots[i].psrc2));
		assert property (@(posedge clock) disable iff (reset)
			live[i] && exp_slots[i].has_dest |-> out_slots[i].pdest == exp_slots[i].pdest)
			else mismatch("pdest", i, $sampled(exp_slots[i].pdest), $sampled(out_slots[i].pdest));
		assert property (@(posedge clock) disable iff (reset) live[i] && exp_slots[i].has_dest
			|-> out_slots[i].prev_pdest == exp_slots[i].prev_pdest)
			else mismatch("prev_pdest", i, $sampled(exp_slots[i].prev_pdest),
				$sampled(out_slots[i].prev_pdest));
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run("Watchdog expired before the stimulus finished");
	end

	initial begin
		void'($urandom(5983));
		reset = 1'b1;
		in_slots = '0;
		in_recover = 1'b0;
		ret_slots = '0;
		hold_slots = '0;
		exp_slots = '0;
		hold_valid = 1'b0;
		exp_valid = 1'b0;
		hold_credits = cred_t'(`RN_WIDTH);
		exp_credits = cred_t'(`RN_WIDTH);
		for (int i = 0; i < `ARCH_REGS; i++) begin
			spec_m[i] = ptag_t'(i);
			arch_m[i] = ptag_t'(i);
		end
		for (int i = 0; i < `PHYS_REGS - `ARCH_REGS; i++)
			free_q.push_back(ptag_t'(`ARCH_REGS + i));
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		for (int cyc = 0; cyc < N_CYCLES + 3; cyc++) begin
			@(posedge clock);
			exp_slots <= hold_slots; // Bundle driven last edge lands now
			exp_valid <= hold_valid;
			exp_credits <= hold_credits;
			run_cycle(cyc);
		end
		repeat (2) @(posedge clock);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+common
common/rename_pkg.sv
common/free_port_if.sv
rtl/free_list/free_list.sv
rtl/map_table/map_table.sv
rtl/rename_stage.sv
rtl/rename_unit.sv
sim/rename_tb.sv

// ==== Bender.yml ====
package:
  name: rename_unit

sources:
  - include_dirs:
      - common
    files:
      - common/rename_pkg.sv
      - common/free_port_if.sv
      - rtl/free_list/free_list.sv
      - rtl/map_table/map_table.sv
      - rtl/rename_stage.sv
      - rtl/rename_unit.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/rename_tb.sv
